//--- verilog/uart_word_pkg.sv
`default_nettype none

package uart_word_pkg;

    ////////////////////////////////////////////////////////////
    // Serial line timing
    ////////////////////////////////////////////////////////////

    // Clock cycles per serial bit
    localparam int CLKS_PER_BIT = 16;

    // Bytes packed into one word, LSB first
    localparam int BYTES_PER_WORD = 4;

    ////////////////////////////////////////////////////////////
    // Data types
    ////////////////////////////////////////////////////////////

    // One data byte as seen on the serial line
    typedef logic [7:0] byte_t;

    // Assembled word, also the running sum
    typedef logic [31:0] word_t;

    // Lane of a byte inside a word, 0 is bits 7:0
    typedef logic [1:0] byte_idx_t;

    // Oversampling tick count or data bit count
    typedef logic [3:0] bit_cnt_t;

    ////////////////////////////////////////////////////////////
    // State machines
    ////////////////////////////////////////////////////////////

    // Receiver FSM
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    // Transmitter FSM
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

endpackage

`default_nettype wire

//--- verilog/uart_rx.sv
`default_nettype none

module uart_rx
    import uart_word_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  rx,
    output byte_t rx_byte,
    output logic  rx_byte_valid,
    output logic  frame_error
);

    ////////////////////////////////////////////////////////////
    // Input synchronizer and edge detect
    ////////////////////////////////////////////////////////////

    logic rx_meta;
    logic rx_sync;
    logic rx_last;

    // Two flops against metastability, third one for the edge
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_last <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_last <= rx_sync;
        end
    end

    ////////////////////////////////////////////////////////////
    // Receive FSM
    ////////////////////////////////////////////////////////////

    rx_state_t state;
    bit_cnt_t  tick;
    bit_cnt_t  bit_idx;
    byte_t     shift;

    // Shift register already holds the byte when the strobe fires
    assign rx_byte = shift;

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= RX_IDLE;
            tick          <= '0;
            bit_idx       <= '0;
            rx_byte_valid <= 1'b0;
            frame_error   <= 1'b0;
        end else begin
            // Strobes last one cycle only
            rx_byte_valid <= 1'b0;
            frame_error   <= 1'b0;
            unique case (state)
                RX_IDLE: begin
                    tick <= '0;
                    // Falling edge marks a possible start bit
                    if (rx_last && !rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (tick == bit_cnt_t'(CLKS_PER_BIT / 2 - 1)) begin
                        tick    <= '0;
                        bit_idx <= '0;
                        // Line back high at mid bit, just a glitch
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (tick == bit_cnt_t'(CLKS_PER_BIT - 1)) begin
                        tick  <= '0;
                        // Sample at mid bit, LSB arrives first
                        shift <= {rx_sync, shift[7:1]};
                        if (bit_idx == 4'd7) begin
                            state <= RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (tick == bit_cnt_t'(CLKS_PER_BIT - 1)) begin
                        tick  <= '0;
                        state <= RX_IDLE;
                        // Low stop bit drops the byte
                        if (rx_sync) begin
                            rx_byte_valid <= 1'b1;
                        end else begin
                            frame_error <= 1'b1;
                        end
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/rx_word_assembler.sv
`default_nettype none

module rx_word_assembler
    import uart_word_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  byte_t rx_byte,
    input  logic  rx_byte_valid,
    output word_t word,
    output logic  word_valid
);

    ////////////////////////////////////////////////////////////
    // Byte packing
    ////////////////////////////////////////////////////////////

    byte_idx_t pos;
    word_t     stage;
    word_t     stage_nxt;
    logic      last_lane;

    // Drop the incoming byte into its lane
    always_comb begin
        stage_nxt = stage;
        stage_nxt[{pos, 3'b000} +: 8] = rx_byte;
    end

    assign last_lane = (pos == byte_idx_t'(BYTES_PER_WORD - 1));

    // Position and strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            pos        <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= rx_byte_valid && last_lane;
            if (rx_byte_valid) begin
                // Wrap back to bits 7:0 after the top lane
                pos <= last_lane ? '0 : pos + 1'b1;
            end
        end
    end

    // Staging and output words carry data only
    always_ff @(posedge clk) begin
        if (rx_byte_valid) begin
            stage <= stage_nxt;
            if (last_lane) begin
                word <= stage_nxt;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/word_accumulator.sv
`default_nettype none

module word_accumulator
    import uart_word_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  word_t word,
    input  logic  word_valid,
    output word_t sum,
    output logic  sum_valid
);

    ////////////////////////////////////////////////////////////
    // Running sum
    ////////////////////////////////////////////////////////////

    word_t total;
    word_t total_nxt;

    // 32-bit add, carry out is dropped so it wraps
    assign total_nxt = total + word;

    always_ff @(posedge clk) begin
        if (rst) begin
            total     <= '0;
            sum_valid <= 1'b0;
        end else begin
            // New total shows up together with the strobe
            sum_valid <= word_valid;
            if (word_valid) begin
                total <= total_nxt;
            end
        end
    end

    // Sum port follows the register
    assign sum = total;

endmodule

`default_nettype wire

//--- verilog/tx_word_serializer.sv
`default_nettype none

module tx_word_serializer
    import uart_word_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  word_t sum,
    input  logic  sum_valid,
    input  logic  tx_busy,
    output byte_t tx_byte,
    output logic  tx_start
);

    ////////////////////////////////////////////////////////////
    // Active word plus one pending slot
    ////////////////////////////////////////////////////////////

    word_t     active;
    logic      active_valid;
    byte_idx_t pos;
    word_t     pending;
    logic      pending_valid;

    word_t     active_nxt;
    logic      active_valid_nxt;
    byte_idx_t pos_nxt;
    word_t     pending_nxt;
    logic      pending_valid_nxt;
    logic      issue;
    logic      last_lane;

    // Busy rises a cycle after the pulse, so block that cycle too
    assign issue     = active_valid && !tx_busy && !tx_start;
    assign last_lane = (pos == byte_idx_t'(BYTES_PER_WORD - 1));

    always_comb begin
        active_nxt        = active;
        active_valid_nxt  = active_valid;
        pos_nxt           = pos;
        pending_nxt       = pending;
        pending_valid_nxt = pending_valid;
        if (issue) begin
            if (last_lane) begin
                // Word done, promote whatever waits
                active_nxt        = pending;
                active_valid_nxt  = pending_valid;
                pending_valid_nxt = 1'b0;
                pos_nxt           = '0;
            end else begin
                pos_nxt = pos + 1'b1;
            end
        end
        // New sum goes to the free slot
        if (sum_valid) begin
            if (!active_valid_nxt) begin
                active_nxt       = sum;
                active_valid_nxt = 1'b1;
            end else begin
                // A full pending slot is overwritten
                pending_nxt       = sum;
                pending_valid_nxt = 1'b1;
            end
        end
    end

    // Control state
    always_ff @(posedge clk) begin
        if (rst) begin
            active_valid  <= 1'b0;
            pending_valid <= 1'b0;
            pos           <= '0;
            tx_start      <= 1'b0;
        end else begin
            active_valid  <= active_valid_nxt;
            pending_valid <= pending_valid_nxt;
            pos           <= pos_nxt;
            tx_start      <= issue;
        end
    end

    // Data path
    always_ff @(posedge clk) begin
        active  <= active_nxt;
        pending <= pending_nxt;
        if (issue) begin
            tx_byte <= active[{pos, 3'b000} +: 8];
        end
    end

endmodule

`default_nettype wire

//--- verilog/uart_tx.sv
`default_nettype none

module uart_tx
    import uart_word_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  byte_t tx_byte,
    input  logic  tx_start,
    output logic  tx,
    output logic  tx_busy
);

    ////////////////////////////////////////////////////////////
    // Transmit FSM
    ////////////////////////////////////////////////////////////

    tx_state_t state;
    bit_cnt_t  tick;
    bit_cnt_t  bit_idx;
    byte_t     shift;
    logic      bit_end;

    // Last cycle of the current bit
    assign bit_end = (tick == bit_cnt_t'(CLKS_PER_BIT - 1));

    // Busy from the cycle after start to the end of stop
    assign tx_busy = (state != TX_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= TX_IDLE;
            tick    <= '0;
            bit_idx <= '0;
            tx      <= 1'b1;
        end else begin
            unique case (state)
                TX_IDLE: begin
                    tick <= '0;
                    if (tx_start) begin
                        // Start bit goes out right away
                        tx    <= 1'b0;
                        shift <= tx_byte;
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        tick    <= '0;
                        bit_idx <= '0;
                        tx      <= shift[0];
                        shift   <= {1'b1, shift[7:1]};
                        state   <= TX_DATA;
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        tick <= '0;
                        if (bit_idx == 4'd7) begin
                            // Eight bits sent, stop bit is high
                            tx    <= 1'b1;
                            state <= TX_STOP;
                        end else begin
                            tx      <= shift[0];
                            shift   <= {1'b1, shift[7:1]};
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        tick  <= '0;
                        state <= TX_IDLE;
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                default: begin
                    tx    <= 1'b1;
                    state <= TX_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/uart_word_top.sv
`default_nettype none

module uart_word_top
    import uart_word_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic rx,
    output logic tx,
    output logic frame_error
);

    ////////////////////////////////////////////////////////////
    // Links between the blocks
    ////////////////////////////////////////////////////////////

    byte_t rx_byte;
    logic  rx_byte_valid;
    word_t word;
    logic  word_valid;
    word_t sum;
    logic  sum_valid;
    byte_t tx_byte;
    logic  tx_start;
    logic  tx_busy;

    // Input side
    uart_rx u_uart_rx (
        .clk           (clk),
        .rst           (rst),
        .rx            (rx),
        .rx_byte       (rx_byte),
        .rx_byte_valid (rx_byte_valid),
        .frame_error   (frame_error)
    );

    rx_word_assembler u_rx_word_assembler (
        .clk           (clk),
        .rst           (rst),
        .rx_byte       (rx_byte),
        .rx_byte_valid (rx_byte_valid),
        .word          (word),
        .word_valid    (word_valid)
    );

    // Running sum
    word_accumulator u_word_accumulator (
        .clk        (clk),
        .rst        (rst),
        .word       (word),
        .word_valid (word_valid),
        .sum        (sum),
        .sum_valid  (sum_valid)
    );

    // Output side
    tx_word_serializer u_tx_word_serializer (
        .clk       (clk),
        .rst       (rst),
        .sum       (sum),
        .sum_valid (sum_valid),
        .tx_busy   (tx_busy),
        .tx_byte   (tx_byte),
        .tx_start  (tx_start)
    );

    uart_tx u_uart_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_byte  (tx_byte),
        .tx_start (tx_start),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

endmodule

`default_nettype wire

//--- tests/uart_word_tb.sv
`default_nettype none

module uart_word_tb
    import uart_word_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic clk = 1'b0;
    logic rst;
    logic rx;
    logic tx;
    logic frame_error;

    int    error_count;
    int    timeout_count;
    // Running sum the DUT should hold
    word_t model_sum;
    word_t rnd;

    uart_word_top UUT (
        .clk         (clk),
        .rst         (rst),
        .rx          (rx),
        .tx          (tx),
        .frame_error (frame_error)
    );

    // 40 ns period, starts low
    always begin
        clk = 1'b0;
        #20;
        clk = 1'b1;
        #20;
    end

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            error_count = error_count + 1;
            $display("[FAIL] %0t ns: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
        if (actual !== expected) begin
            error_count = error_count + 1;
            $display("[FAIL] %0t ns: %s expected 0x%02h, got 0x%02h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            error_count = error_count + 1;
            $display("[FAIL] %0t ns: %s expected 0x%08h, got 0x%08h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        timeout_count = timeout_count + 1;
        $display("Timeout at %0t ns: %s", $time, what);
    endtask

    ////////////////////////////////////////////////////////////
    // Serial driver, changes rx on the falling edge
    ////////////////////////////////////////////////////////////

    // One bit time, caller sits on a falling edge
    task automatic drive_bit(input logic level);
        rx = level;
        repeat (CLKS_PER_BIT) @(negedge clk);
    endtask

    // 8N1 frame, stop level selectable to force a framing error
    task automatic send_byte(input byte_t data, input logic stop_level);
        byte_t shift;
        int    i;
        shift = data;
        drive_bit(1'b0);
        for (i = 0; i < 8; i++) begin
            drive_bit(shift[0]);
            shift = shift >> 1;
        end
        drive_bit(stop_level);
        // Line back to idle
        rx = 1'b1;
    endtask

    // Four frames, LSB first, no gap
    task automatic send_word(input word_t w);
        word_t cur;
        int    i;
        cur = w;
        for (i = 0; i < BYTES_PER_WORD; i++) begin
            send_byte(cur[7:0], 1'b1);
            cur = cur >> 8;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Serial monitor on tx
    ////////////////////////////////////////////////////////////

    task automatic recv_byte(input int timeout, output byte_t data, output logic ok);
        int    waited;
        int    i;
        byte_t bits;
        waited = 0;
        bits   = '0;
        data   = '0;
        ok     = 1'b0;
        // Hunt for the start edge
        while (tx !== 1'b0 && waited < timeout) begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (tx !== 1'b0) begin
            report_timeout("no start bit on tx");
        end else begin
            // Middle of the start bit
            repeat (CLKS_PER_BIT / 2) @(negedge clk);
            check_bit("tx start bit", 1'b0, tx);
            for (i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                bits = {tx, bits[7:1]};
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            check_bit("tx stop bit", 1'b1, tx);
            data = bits;
            ok   = 1'b1;
        end
    endtask

    // Bytes after the first follow within a few bit times
    task automatic recv_word(input int first_timeout, output word_t data, output logic ok);
        byte_t b;
        logic  b_ok;
        int    i;
        data = '0;
        ok   = 1'b1;
        for (i = 0; i < BYTES_PER_WORD; i++) begin
            if (ok) begin
                recv_byte(i == 0 ? first_timeout : 4 * CLKS_PER_BIT, b, b_ok);
                data = {b, data[31:8]};
                ok   = b_ok;
            end
        end
    endtask

    task automatic wait_frame_error(input int timeout);
        int waited;
        waited = 0;
        while (frame_error !== 1'b1 && waited < timeout) begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (frame_error !== 1'b1) begin
            report_timeout("frame_error never pulsed");
        end else begin
            // Pulse lasts one cycle
            @(negedge clk);
            check_bit("frame_error", 1'b0, frame_error);
        end
    endtask

    // Send one word and check the returned sum
    task automatic exchange_word(input word_t w);
        word_t got;
        logic  ok;
        // 32-bit add, carry dropped
        model_sum = model_sum + w;
        fork
            send_word(w);
            // Reply follows four input frames, allow six
            recv_word(6 * 10 * CLKS_PER_BIT, got, ok);
        join
        if (ok) begin
            check_word("tx word", model_sum, got);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic idle_after_reset();
        int   n;
        logic bad;
        bad = 1'b0;
        for (n = 0; n < 200 && !bad; n++) begin
            @(negedge clk);
            if (tx !== 1'b1 || frame_error !== 1'b0) begin
                check_bit("tx", 1'b1, tx);
                check_bit("frame_error", 1'b0, frame_error);
                bad = 1'b1;
            end
        end
    endtask

    task automatic single_word();
        word_t exp;
        word_t got;
        byte_t b;
        logic  ok;
        int    k;
        model_sum = model_sum + 32'h4433_2211;
        exp       = model_sum;
        got       = '0;
        ok        = 1'b1;
        fork
            send_word(32'h4433_2211);
            begin
                for (k = 0; k < BYTES_PER_WORD && ok; k++) begin
                    recv_byte(k == 0 ? 6 * 10 * CLKS_PER_BIT : 4 * CLKS_PER_BIT, b, ok);
                    if (ok) begin
                        check_byte("tx byte", exp[7:0], b);
                    end
                    exp = exp >> 8;
                    got = {b, got[31:8]};
                end
            end
        join
        if (ok) begin
            check_word("tx word", model_sum, got);
        end
    endtask

    task automatic accumulate_and_wrap();
        int n;
        // Land on all ones, then carry past the top
        exchange_word(~model_sum);
        exchange_word(32'h0000_0100);
        for (n = 0; n < 20; n++) begin
            rnd = $urandom();
            exchange_word(rnd);
        end
    endtask

    task automatic framing_error_recovery();
        int   n;
        logic started;
        rnd = $urandom();
        fork
            send_byte(rnd[7:0], 1'b0);
            wait_frame_error(2 * 10 * CLKS_PER_BIT);
        join
        // Dropped byte must not produce a reply
        started = 1'b0;
        for (n = 0; n < 60 * CLKS_PER_BIT; n++) begin
            @(negedge clk);
            if (tx !== 1'b1) begin
                started = 1'b1;
            end
        end
        if (started) begin
            error_count = error_count + 1;
            $display("Error at %0t ns: tx frame started after a dropped byte", $time);
        end
        // Assembler still at lane 0
        rnd = $urandom();
        exchange_word(rnd);
    endtask

    task automatic back_to_back_words();
        word_t w1;
        word_t w2;
        word_t s1;
        word_t s2;
        word_t got1;
        word_t got2;
        logic  ok1;
        logic  ok2;
        w1        = $urandom();
        w2        = $urandom();
        s1        = model_sum + w1;
        s2        = s1 + w2;
        model_sum = s2;
        fork
            begin
                send_word(w1);
                send_word(w2);
            end
            begin
                recv_word(6 * 10 * CLKS_PER_BIT, got1, ok1);
                if (ok1) begin
                    check_word("tx word 1", s1, got1);
                end
                // Second reply right behind the first
                recv_word(6 * 10 * CLKS_PER_BIT, got2, ok2);
                if (ok2) begin
                    check_word("tx word 2", s2, got2);
                end
            end
        join
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rst           = 1'b1;
        rx            = 1'b1;
        error_count   = 0;
        timeout_count = 0;
        model_sum     = '0;
        rnd           = $urandom(32'hea00_ce91);
        repeat (16) @(negedge clk);
        rst = 1'b0;

        idle_after_reset();
        single_word();
        accumulate_and_wrap();
        framing_error_recovery();
        back_to_back_words();

        $display("Summary: %0d errors, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
verilog/uart_word_pkg.sv
verilog/uart_rx.sv
verilog/rx_word_assembler.sv
verilog/word_accumulator.sv
verilog/tx_word_serializer.sv
verilog/uart_tx.sv
verilog/uart_word_top.sv
tests/uart_word_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --timescale 1ns/100ps \
    --top-module uart_word_tb -f vlog.f -o uart_word_sim \
    && ./obj_dir/uart_word_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -qx "test passed" sim.log && exit 0 || exit 1
